// File: conv_store_pkg.sv
package conv_store_pkg;

  ////////////////////
  // widths
  typedef logic [31:0]  ddr_adr_t;
  typedef logic [15:0]  count_t;
  typedef logic [3:0]   log2_t;
  typedef logic [511:0] ddr_word_t;
  typedef logic [255:0] half_word_t;

  // mode 0 packs two half reads, mode 1 passes full words
  typedef enum logic {mode_pack, mode_pass} store_mode_t;

  typedef enum logic [1:0] {st_idle, st_cmd, st_burst, st_done} ctrl_state_t;

  ////////////////////
  // systolic array geometry
  localparam int sa_rows = 4;
  localparam int sa_cols = 3;
  localparam int fifo_num = sa_rows * sa_cols;
  // channels held by one fifo in mode 0, doubled in mode 1
  localparam int ch_group_pack = 16;

  // two output channels per ddr word
  localparam int ch_per_word_log2 = 1;
  localparam int pixels_per_row_log2 = 5;

  // ddr word address of channel ch in tile row row
  function automatic ddr_adr_t word_adr(input ddr_adr_t base, input count_t ox_start,
                                        input count_t oy_start, input count_t of_start,
                                        input log2_t of_log2, input log2_t ox_log2,
                                        input count_t row, input count_t ch);
    log2_t row_shift;
    log2_t x_shift;
    ddr_adr_t row_term;
    ddr_adr_t x_term;
    ddr_adr_t ch_term;
    row_shift = of_log2 + ox_log2 - log2_t'(ch_per_word_log2 + pixels_per_row_log2);
    x_shift   = of_log2 - log2_t'(ch_per_word_log2);
    row_term  = ddr_adr_t'(oy_start - 16'd1 + row) << row_shift;
    x_term    = (ddr_adr_t'(ox_start - 16'd1) << x_shift) >> pixels_per_row_log2;
    ch_term   = ddr_adr_t'(of_start - 16'd1 + ch) >> ch_per_word_log2;
    return base + row_term + x_term + ch_term;
  endfunction

endpackage

// File: tile_cfg_if.sv
interface tile_cfg_if import conv_store_pkg::*; ();

  ddr_adr_t    layer_base;
  store_mode_t mode;
  count_t      ox_start;
  count_t      oy_start;
  count_t      of_start;
  count_t      pof;
  count_t      poy;
  log2_t       of_log2;
  log2_t       ox_log2;
  // channels per fifo, 16 or 32
  count_t      ch_group;

  modport ctrl (output layer_base, mode, ox_start, oy_start, of_start, pof, poy,
                       of_log2, ox_log2, ch_group);

  modport cmd (input layer_base, ox_start, oy_start, of_start, pof, poy, of_log2, ox_log2);

  modport walk (input layer_base, mode, ox_start, oy_start, of_start, pof, poy,
                      of_log2, ox_log2, ch_group);

endinterface

// File: store_ctrl.sv
module store_ctrl import conv_store_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  logic     start,
  input  logic     ddr_cmd_ready,
  input  ddr_adr_t layer_base,
  input  logic     mode,
  input  count_t   ox_start,
  input  count_t   oy_start,
  input  count_t   of_start,
  input  count_t   pof,
  input  count_t   poy,
  input  log2_t    of_log2,
  input  log2_t    ox_log2,
  tile_cfg_if.ctrl cfg,
  output logic     cmd_go,
  output logic     burst_go,
  input  count_t   cmd_len,
  input  logic     word_done,
  input  logic     tile_last
);

  ctrl_state_t state;
  logic        ready_q;
  logic        go_q;
  count_t      word_cnt;
  logic        burst_end;

  ////////////////////
  // tile configuration, taken on start
  always_ff @(posedge clk) begin
    if (state == st_idle && start) begin
      cfg.layer_base <= layer_base;
      cfg.mode       <= store_mode_t'(mode);
      cfg.ox_start   <= ox_start;
      cfg.oy_start   <= oy_start;
      cfg.of_start   <= of_start;
      cfg.pof        <= pof;
      cfg.poy        <= poy;
      cfg.of_log2    <= of_log2;
      cfg.ox_log2    <= ox_log2;
      cfg.ch_group   <= (store_mode_t'(mode) == mode_pack) ? count_t'(ch_group_pack) :
                                                              count_t'(2 * ch_group_pack);
    end
  end

  // ready is looked at one cycle late
  assign cmd_go    = (state == st_cmd) && ready_q;
  assign burst_end = word_done && (word_cnt == cmd_len - 16'd1);

  ////////////////////
  // sequencing
  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= st_idle;
      ready_q  <= 1'b0;
      go_q     <= 1'b0;
      burst_go <= 1'b0;
      word_cnt <= '0;
    end else begin
      ready_q  <= ddr_cmd_ready;
      // burst starts once the command is out
      go_q     <= cmd_go;
      burst_go <= go_q;
      case (state)
        st_idle: begin
          if (start) state <= st_cmd;
        end
        st_cmd: begin
          if (cmd_go) begin
            state    <= st_burst;
            word_cnt <= '0;
          end
        end
        st_burst: begin
          if (word_done) begin
            word_cnt <= word_cnt + 16'd1;
            if (burst_end) state <= tile_last ? st_done : st_cmd;
          end
        end
        st_done: state <= st_idle;
        default: state <= st_idle;
      endcase
    end
  end

endmodule

// File: burst_cmd_gen.sv
module burst_cmd_gen import conv_store_pkg::*; #(
  parameter int burst_max = 32
) (
  input  logic     clk,
  input  logic     reset,
  tile_cfg_if.cmd  cfg,
  input  logic     cmd_go,
  output logic     cmd_valid,
  output ddr_adr_t cmd_adr,
  output count_t   cmd_len
);

  // position of the next command inside the tile
  count_t ch_cnt;
  count_t row_cnt;
  count_t ch_left;
  count_t words_left;
  count_t len;
  count_t next_ch;

  assign ch_left    = cfg.pof - ch_cnt;
  assign words_left = ch_left >> ch_per_word_log2;
  assign len        = (words_left > count_t'(burst_max)) ? count_t'(burst_max) : words_left;
  assign next_ch    = ch_cnt + (len << ch_per_word_log2);

  ////////////////////
  // command output
  always_ff @(posedge clk) begin
    if (reset) begin
      cmd_valid <= 1'b0;
    end else begin
      cmd_valid <= cmd_go;
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_go) begin
      cmd_len <= len;
      cmd_adr <= word_adr(cfg.layer_base, cfg.ox_start, cfg.oy_start, cfg.of_start,
                          cfg.of_log2, cfg.ox_log2, row_cnt, ch_cnt);
    end
  end

  // advance channel, wrap to next row at row end
  always_ff @(posedge clk) begin
    if (reset) begin
      ch_cnt  <= '0;
      row_cnt <= '0;
    end else if (cmd_go) begin
      if (next_ch >= cfg.pof) begin
        ch_cnt  <= '0;
        row_cnt <= (row_cnt == cfg.poy - 16'd1) ? '0 : row_cnt + 16'd1;
      end else begin
        ch_cnt <= next_ch;
      end
    end
  end

endmodule

// File: fifo_walker.sv
module fifo_walker import conv_store_pkg::*; #(
  parameter int burst_max = 32
) (
  input  logic                clk,
  input  logic                reset,
  tile_cfg_if.walk            cfg,
  input  logic                burst_go,
  input  logic                word_done,
  input  count_t              cmd_len,
  output logic [fifo_num-1:0] fifo_rds,
  output ddr_adr_t            data_adr,
  output logic                tile_last
);

  // mode 0 needs two reads per word
  localparam int left_w = $clog2(burst_max) + 2;

  logic [left_w-1:0] rd_left;
  logic              issue;
  count_t            step;
  count_t            ch;
  count_t            ch_in_grp;
  count_t            grp;
  count_t            row;
  count_t            next_ch;
  count_t            fifo_idx;
  logic              row_end;
  logic              grp_end;
  logic              row_last;
  logic              rd_last;
  logic              last_pend;
  ddr_adr_t          rd_adr;

  assign step     = (cfg.mode == mode_pack) ? 16'd1 : 16'd2;
  assign issue    = burst_go || (rd_left != '0);
  assign next_ch  = ch + step;
  assign row_end  = next_ch >= cfg.pof;
  assign grp_end  = (ch_in_grp + step) >= cfg.ch_group;
  assign row_last = row == cfg.poy - 16'd1;
  assign fifo_idx = count_t'(row * sa_rows) + grp;

  ////////////////////
  // reads left in this burst
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_left <= '0;
    end else if (burst_go) begin
      rd_left <= left_w'(((cfg.mode == mode_pack) ? cmd_len << 1 : cmd_len) - 16'd1);
    end else if (rd_left != '0) begin
      rd_left <= rd_left - 1'b1;
    end
  end

  // channel -> group -> row
  always_ff @(posedge clk) begin
    if (reset) begin
      ch        <= '0;
      ch_in_grp <= '0;
      grp       <= '0;
      row       <= '0;
    end else if (issue) begin
      if (row_end) begin
        ch        <= '0;
        ch_in_grp <= '0;
        grp       <= '0;
        row       <= row_last ? '0 : row + 16'd1;
      end else if (grp_end) begin
        ch        <= next_ch;
        ch_in_grp <= '0;
        grp       <= grp + 16'd1;
      end else begin
        ch        <= next_ch;
        ch_in_grp <= ch_in_grp + step;
      end
    end
  end

  ////////////////////
  // read strobes
  always_ff @(posedge clk) begin
    if (reset) begin
      fifo_rds <= '0;
      rd_last  <= 1'b0;
    end else begin
      fifo_rds <= issue ? (fifo_num'(1) << fifo_idx) : '0;
      rd_last  <= issue && row_end && row_last;
    end
  end

  // address follows its read, then lines up with the data
  always_ff @(posedge clk) begin
    if (issue) begin
      rd_adr <= word_adr(cfg.layer_base, cfg.ox_start, cfg.oy_start, cfg.of_start,
                         cfg.of_log2, cfg.ox_log2, row, ch);
    end
    data_adr <= rd_adr;
  end

  // last read seen, wait for its word
  always_ff @(posedge clk) begin
    if (reset) begin
      last_pend <= 1'b0;
    end else if (rd_last) begin
      last_pend <= 1'b1;
    end else if (word_done) begin
      last_pend <= 1'b0;
    end
  end

  assign tile_last = last_pend && word_done;

endmodule

// File: word_packer.sv
module word_packer import conv_store_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  store_mode_t mode,
  input  logic        rd_any,
  input  ddr_word_t   fifo_data,
  output logic        data_valid,
  output logic        word_done,
  output ddr_word_t   data
);

  localparam int half_w = $bits(half_word_t);

  // fifo data is present the cycle after a read
  logic       rd_q;
  // high on the second read of a pair
  logic       phase;
  half_word_t low_half;

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_q  <= 1'b0;
      phase <= 1'b0;
    end else begin
      rd_q <= rd_any;
      if (rd_q && mode == mode_pack) phase <= ~phase;
    end
  end

  // older read becomes the lower half
  always_ff @(posedge clk) begin
    if (rd_q && !phase) low_half <= fifo_data[half_w-1:0];
  end

  assign data_valid = rd_q && (mode == mode_pass || phase);
  assign word_done  = data_valid;

  assign data = !data_valid         ? '0 :
                (mode == mode_pass) ? fifo_data :
                                      {fifo_data[half_w-1:0], low_half};

endmodule

// File: conv_store_top.sv
module conv_store_top import conv_store_pkg::*; #(
  parameter int burst_max = 32
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                start,
  input  logic                ddr_cmd_ready,
  // layer and tile configuration
  input  ddr_adr_t            layer_base,
  input  logic                mode,
  input  count_t              ox_start,
  input  count_t              oy_start,
  input  count_t              of_start,
  input  count_t              pof,
  input  count_t              poy,
  input  log2_t               of_log2,
  input  log2_t               ox_log2,
  // systolic array output fifos
  input  ddr_word_t           fifo_data,
  output logic [fifo_num-1:0] fifo_rds,
  // ddr command and data
  output logic                cmd_valid,
  output ddr_adr_t            cmd_adr,
  output count_t              cmd_len,
  output logic                data_valid,
  output ddr_adr_t            data_adr,
  output ddr_word_t           data,
  output logic                store_fin
);

  logic cmd_go;
  logic burst_go;
  logic word_done;
  logic tile_last;
  logic rd_any;

  tile_cfg_if cfg ();

  assign rd_any    = |fifo_rds;
  assign store_fin = tile_last;

  store_ctrl store_ctrl_inst (
    .clk, .reset, .start, .ddr_cmd_ready,
    .layer_base, .mode, .ox_start, .oy_start, .of_start, .pof, .poy, .of_log2, .ox_log2,
    .cfg (cfg.ctrl),
    .cmd_go, .burst_go, .cmd_len, .word_done, .tile_last
  );

  burst_cmd_gen #(.burst_max(burst_max)) burst_cmd_gen_inst (
    .clk, .reset,
    .cfg (cfg.cmd),
    .cmd_go, .cmd_valid, .cmd_adr, .cmd_len
  );

  fifo_walker #(.burst_max(burst_max)) fifo_walker_inst (
    .clk, .reset,
    .cfg (cfg.walk),
    .burst_go, .word_done, .cmd_len, .fifo_rds, .data_adr, .tile_last
  );

  word_packer word_packer_inst (
    .clk, .reset,
    .mode (cfg.mode),
    .rd_any, .fifo_data, .data_valid, .word_done, .data
  );

endmodule

// File: conv_store_chk.sv
module conv_store_chk import conv_store_pkg::*; (
  input logic                clk,
  input logic                reset,
  input logic                cmd_valid,
  input count_t              cmd_len,
  input logic                data_valid,
  input logic [fifo_num-1:0] fifo_rds,
  input logic                store_fin
);

  timeunit 1ns;
  timeprecision 1ps;

  // words still owed to the last command
  count_t words_owed;
  // failed assertions so far
  int     fail_count = 0;

  always_ff @(posedge clk) begin
    if (reset) begin
      words_owed <= '0;
    end else if (cmd_valid) begin
      words_owed <= cmd_len;
    end else if (data_valid && words_owed != '0) begin
      words_owed <= words_owed - 16'd1;
    end
  end

  ////////////////////
  // strobes and bursts
  rds_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(fifo_rds))
    else begin
      fail_count++;
      $error("several fifo read strobes high together");
    end

  cmd_not_mid_burst: assert property (@(posedge clk) disable iff (reset)
    cmd_valid |-> words_owed == '0)
    else begin
      fail_count++;
      $error("command issued inside a burst");
    end

  data_in_burst: assert property (@(posedge clk) disable iff (reset)
    data_valid |-> words_owed != '0)
    else begin
      fail_count++;
      $error("data word with no words owed");
    end

  cmd_single: assert property (@(posedge clk) disable iff (reset) cmd_valid |=> !cmd_valid)
    else begin
      fail_count++;
      $error("cmd_valid longer than one cycle");
    end

  fin_on_last_word: assert property (@(posedge clk) disable iff (reset)
    store_fin |-> words_owed == 16'd1)
    else begin
      fail_count++;
      $error("store_fin not on the last word of a burst");
    end

  quiet_after_reset: assert property (@(posedge clk)
    $fell(reset) |-> !cmd_valid && !data_valid && fifo_rds == '0 && !store_fin)
    else begin
      fail_count++;
      $error("strobe high right after reset");
    end

endmodule

// File: conv_store_tb.sv
module conv_store_tb import conv_store_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int burst_max    = 32;
  localparam int n_tiles      = 6;
  localparam int tile_timeout = 4000;

  // one table row with the expected command count of the tile
  typedef struct packed {
    logic     mode;
    count_t   pof;
    count_t   poy;
    count_t   ox_start;
    count_t   oy_start;
    count_t   of_start;
    log2_t    of_log2;
    log2_t    ox_log2;
    ddr_adr_t base;
    count_t   n_cmds;
  } tile_t;

  logic                clk;
  logic                reset;
  logic                start;
  logic                ddr_cmd_ready;
  ddr_adr_t            layer_base;
  logic                mode;
  count_t              ox_start;
  count_t              oy_start;
  count_t              of_start;
  count_t              pof;
  count_t              poy;
  log2_t               of_log2;
  log2_t               ox_log2;
  ddr_word_t           fifo_data;
  logic [fifo_num-1:0] fifo_rds;
  logic                cmd_valid;
  ddr_adr_t            cmd_adr;
  count_t              cmd_len;
  logic                data_valid;
  ddr_adr_t            data_adr;
  ddr_word_t           data;
  logic                store_fin;

  tile_t     tiles [n_tiles];
  count_t    exp_len_q [$];
  ddr_adr_t  exp_adr_q [$];
  ddr_adr_t  exp_dadr_q [$];
  int        exp_fifo_q [$];
  ddr_word_t got_q [$];
  int        rd_count [fifo_num];
  ddr_word_t fifo_next = '0;
  logic      cur_mode = 1'b0;
  bit        monitor_on = 1'b0;
  bit        ready_on = 1'b0;
  logic      rdy_d1 = 1'b0;
  logic      rdy_d2 = 1'b0;
  int        checks = 0;
  int        errors = 0;
  int        timeouts = 0;
  int        fin_count = 0;
  int        tile_cmds = 0;

  conv_store_top #(.burst_max(burst_max)) conv_store_top_inst (
    .clk, .reset, .start, .ddr_cmd_ready,
    .layer_base, .mode, .ox_start, .oy_start, .of_start, .pof, .poy, .of_log2, .ox_log2,
    .fifo_data, .fifo_rds,
    .cmd_valid, .cmd_adr, .cmd_len, .data_valid, .data_adr, .data, .store_fin
  );

  bind conv_store_top conv_store_chk conv_store_chk_inst (
    .clk, .reset, .cmd_valid, .cmd_len, .data_valid, .fifo_rds, .store_fin
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic compare(input string name, input logic [511:0] expected,
                         input logic [511:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAIL %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  // word address from base, row offset, x offset and channel offset
  function automatic ddr_adr_t rule_adr(input tile_t t, input int row, input int ch);
    int       row_shift;
    int       x_shift;
    ddr_adr_t adr;
    row_shift = t.of_log2 - 1 + t.ox_log2 - 5;
    x_shift   = t.of_log2 - 1;
    adr = t.base;
    adr = adr + (ddr_adr_t'(t.oy_start - 1 + row) << row_shift);
    adr = adr + ((ddr_adr_t'(t.ox_start - 1) << x_shift) >> 5);
    adr = adr + (ddr_adr_t'(t.of_start - 1 + ch) >> 1);
    return adr;
  endfunction

  // each lane holds fifo index, read count and random low bits
  function automatic ddr_word_t fifo_word(input int idx, input int count);
    ddr_word_t w;
    for (int lane = 0; lane < 16; lane++) begin
      w[lane*32 +: 32] = {4'(idx), 12'(count), 16'($urandom)};
    end
    return w;
  endfunction

  task automatic load_tile(input tile_t t);
    int ch;
    int words;
    int len;
    int step;
    int grp_size;
    for (int row = 0; row < t.poy; row++) begin
      ch = 0;
      while (ch < t.pof) begin
        words = (t.pof - ch) / 2;
        len   = (words > burst_max) ? burst_max : words;
        exp_len_q.push_back(count_t'(len));
        exp_adr_q.push_back(rule_adr(t, row, ch));
        ch = ch + 2 * len;
      end
    end
    step     = t.mode ? 2 : 1;
    grp_size = t.mode ? 32 : 16;
    // four channel groups per array row
    for (int row = 0; row < t.poy; row++) begin
      for (ch = 0; ch < t.pof; ch = ch + step) begin
        exp_fifo_q.push_back(row * 4 + ch / grp_size);
      end
    end
  endtask

  ////////////////////
  // inputs change 2 ns after the edge
  always @(posedge clk) begin
    #2;
    fifo_data = fifo_next;
    if (ready_on) ddr_cmd_ready = ($urandom_range(3, 0) != 0);
  end

  ////////////////////
  // fifo model and output checks at the falling edge
  always @(negedge clk) begin : monitor
    ddr_word_t older;
    ddr_word_t newer;
    ddr_word_t want;
    count_t    len_e;
    ddr_adr_t  adr_e;
    int        idx;
    bit        last;
    if (monitor_on) begin
      fifo_next = '0;
      if (fifo_rds != '0) begin
        if (!$onehot(fifo_rds)) begin
          errors++;
          $display("ERROR: more than one fifo read strobe high at once");
        end
        idx = 0;
        for (int i = 0; i < fifo_num; i++) begin
          if (fifo_rds[i]) idx = i;
        end
        if (exp_fifo_q.size() == 0) begin
          errors++;
          $display("ERROR: fifo read after the tile's last read");
        end else begin
          compare("fifo index", exp_fifo_q.pop_front(), idx);
        end
        fifo_next = fifo_word(idx, rd_count[idx]);
        rd_count[idx]++;
        got_q.push_back(fifo_next);
      end
      if (cmd_valid) begin
        tile_cmds++;
        if (!rdy_d2) begin
          errors++;
          $display("ERROR: command issued while ddr_cmd_ready was low two cycles before");
        end
        if (exp_dadr_q.size() != 0) begin
          errors++;
          $display("ERROR: command issued before the previous burst was complete");
        end
        if (exp_len_q.size() == 0) begin
          errors++;
          $display("ERROR: more commands than the tile needs");
        end else begin
          len_e = exp_len_q.pop_front();
          adr_e = exp_adr_q.pop_front();
          compare("cmd_len", len_e, cmd_len);
          compare("cmd_adr", adr_e, cmd_adr);
          for (int i = 0; i < len_e; i++) exp_dadr_q.push_back(adr_e + i);
        end
      end
      last = 1'b0;
      if (data_valid) begin
        if (exp_dadr_q.size() == 0) begin
          errors++;
          $display("ERROR: data word outside of any burst");
        end else begin
          compare("data_adr", exp_dadr_q.pop_front(), data_adr);
          last = (exp_dadr_q.size() == 0) && (exp_len_q.size() == 0);
        end
        if (got_q.size() < (cur_mode ? 1 : 2)) begin
          errors++;
          $display("ERROR: data word without enough fifo reads behind it");
        end else begin
          // newer read in the upper half
          if (cur_mode) begin
            want = got_q.pop_front();
          end else begin
            older = got_q.pop_front();
            newer = got_q.pop_front();
            want  = {newer[255:0], older[255:0]};
          end
          compare("data", want, data);
        end
      end else begin
        compare("idle data", '0, data);
      end
      if (data_valid || store_fin) compare("store_fin", last, store_fin);
      if (store_fin) fin_count++;
    end
    rdy_d2 = rdy_d1;
    rdy_d1 = ddr_cmd_ready;
  end

  initial begin
    int unsigned seed;
    int          fin_start;
    int          waited;
    int          assert_fails;
    bit          timed_out;
    seed = $urandom(32'hdadc_e873);
    timed_out     = 1'b0;
    reset         = 1'b1;
    start         = 1'b0;
    ddr_cmd_ready = 1'b0;
    layer_base    = '0;
    mode          = 1'b0;
    ox_start      = '0;
    oy_start      = '0;
    of_start      = '0;
    pof           = '0;
    poy           = '0;
    of_log2       = '0;
    ox_log2       = '0;
    fifo_data     = '0;
    for (int i = 0; i < fifo_num; i++) rd_count[i] = 0;

    //    mode  pof     poy    ox      oy     of     ofl   oxl   base           cmds
    tiles[0] = {1'b0, 16'd64, 16'd3, 16'd1, 16'd1, 16'd1, 4'd6, 4'd5, 32'h0000_1000, 16'd3};
    tiles[1] = {1'b1, 16'd128, 16'd2, 16'd33, 16'd2, 16'd1, 4'd7, 4'd5, 32'h0002_0000, 16'd4};
    tiles[2] = {1'b0, 16'd20, 16'd1, 16'd5, 16'd3, 16'd3, 4'd5, 4'd4, 32'h0000_0400, 16'd1};
    tiles[3] = {1'b1, 16'd96, 16'd3, 16'd1, 16'd1, 16'd5, 4'd7, 4'd6, 32'h8000_0000, 16'd6};
    tiles[4] = {1'b0, 16'd2, 16'd2, 16'd1, 16'd4, 16'd1, 4'd1, 4'd5, 32'h0000_0100, 16'd2};
    tiles[5] = {1'b1, 16'd70, 16'd3, 16'd9, 16'd1, 16'd7, 4'd7, 4'd5, 32'h0010_0000, 16'd6};

    repeat (4) @(posedge clk);
    #2 reset = 1'b0;
    @(negedge clk);
    compare("cmd_valid after reset", 0, cmd_valid);
    compare("data_valid after reset", 0, data_valid);
    compare("fifo_rds after reset", 0, fifo_rds);
    compare("store_fin after reset", 0, store_fin);
    monitor_on = 1'b1;
    ready_on   = 1'b1;

    for (int t = 0; t < n_tiles && !timed_out; t++) begin
      load_tile(tiles[t]);
      cur_mode  = tiles[t].mode;
      tile_cmds = 0;
      fin_start = fin_count;
      @(posedge clk);
      #2;
      mode       = tiles[t].mode;
      pof        = tiles[t].pof;
      poy        = tiles[t].poy;
      ox_start   = tiles[t].ox_start;
      oy_start   = tiles[t].oy_start;
      of_start   = tiles[t].of_start;
      of_log2    = tiles[t].of_log2;
      ox_log2    = tiles[t].ox_log2;
      layer_base = tiles[t].base;
      start      = 1'b1;
      @(posedge clk);
      #2 start = 1'b0;
      waited = 0;
      while (fin_count == fin_start && waited < tile_timeout) begin
        @(posedge clk);
        waited++;
      end
      if (fin_count == fin_start) begin
        timeouts++;
        timed_out = 1'b1;
        $display("ERROR: tile %0d did not finish within %0d cycles", t, tile_timeout);
      end else begin
        repeat (3) @(negedge clk);
        compare("commands per tile", tiles[t].n_cmds, tile_cmds);
        compare("finish pulses per tile", 1, fin_count - fin_start);
        compare("commands left", 0, exp_len_q.size());
        compare("words left", 0, exp_dadr_q.size());
        compare("reads left", 0, exp_fifo_q.size());
      end
    end

    assert_fails = conv_store_top_inst.conv_store_chk_inst.fail_count;
    $display("checks %0d, errors %0d, assertion failures %0d, timeouts %0d",
             checks, errors, assert_fails, timeouts);
    if (errors == 0 && timeouts == 0 && assert_fails == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: build.f
conv_store_pkg.sv
tile_cfg_if.sv
store_ctrl.sv
burst_cmd_gen.sv
fifo_walker.sv
word_packer.sv
conv_store_top.sv
conv_store_chk.sv
conv_store_tb.sv

// File: Bender.yml
package:
  name: conv_store

sources:
  - conv_store_pkg.sv
  - tile_cfg_if.sv
  - store_ctrl.sv
  - burst_cmd_gen.sv
  - fifo_walker.sv
  - word_packer.sv
  - conv_store_top.sv
  - target: test
    files:
      - conv_store_chk.sv
      - conv_store_tb.sv
